/* hdl/isa_pkg.sv */
package isa_pkg;

    // ########################################
    // Operation and region encodings
    // ########################################

    typedef enum logic [3:0] {
        OP_LOAD  = 4'd0,
        OP_STORE = 4'd1,
        OP_SWAP  = 4'd2
    } op_e; // Every other code is illegal.

    typedef enum logic [1:0] {
        REG_MEM = 2'd0,
        REG_IO  = 2'd1,
        REG_BAD = 2'd2
    } region_e;

    localparam logic [8:0] IO_BASE = 9'h1F0; // First I/O register address.
    localparam int unsigned IO_COUNT = 8;

    // ########################################
    // Command formats
    // ########################################

    // Command word as it arrives on the input link.
    typedef struct packed {
        logic [3:0]  tag;
        op_e         op;
        logic [8:0]  addr;
        logic [15:0] data;
    } cmd_t;

    // Decoded command held between decode and execute.
    typedef struct packed {
        logic [3:0]  tag;
        region_e     region;
        logic [7:0]  index;  // Word index inside the selected region.
        logic        wr_en;  // Already cleared for illegal commands.
        logic        rd_ret; // Return the old word instead of the data.
        logic        bad_op;
        logic [15:0] data;
    } dec_t;

endpackage

/* hdl/link_pkg.sv */
package link_pkg;

    // Status returned with every result.
    typedef enum logic [1:0] {
        ST_OK       = 2'd0,
        ST_BAD_ADDR = 2'd1,
        ST_BAD_OP   = 2'd2
    } status_e;

    // Result word as it leaves on the output link.
    typedef struct packed {
        logic [3:0]  tag;
        status_e     status;
        logic [15:0] data; // Zero whenever status is not ST_OK.
    } result_t;

    // ########################################
    // Link credit defaults
    // ########################################

    localparam int unsigned IN_CREDITS  = 4; // Credits the sender starts with.
    localparam int unsigned OUT_CREDITS = 4; // Credits the DUT starts with.

endpackage

/* hdl/credit_fifo.sv */
module credit_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     SIM_CLK,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     full,
    output logic     credit
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t       mem [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           wr;
    logic           rd;

    assign wr = push & ~full; // A push into a full buffer is flagged by the checker.
    assign rd = pop & not_empty;

    assign not_empty = (count != '0);
    assign full      = (count == CW'(DEPTH));
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge SIM_CLK) begin
        if (wr) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= rd; // One credit back per entry that leaves.
            if (wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/address_decode.sv */
module address_decode #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic          SIM_CLK,
    input  logic          arst_n,
    input  logic          cmd_valid,
    input  isa_pkg::cmd_t cmd,
    output logic          cmd_pop,
    output logic          dec_valid,
    output isa_pkg::dec_t dec,
    input  logic          dec_ready
);

    isa_pkg::region_e region;
    logic [7:0]       index;
    logic [8:0]       io_off;
    logic             wr_en;
    logic             rd_ret;
    logic             bad_op;

    // The output register takes a new command when it is empty or being drained.
    assign cmd_pop = cmd_valid & (~dec_valid | dec_ready);

    assign io_off = cmd.addr - isa_pkg::IO_BASE;

    // ########################################
    // Address region
    // ########################################

    always_comb begin
        region = isa_pkg::REG_BAD;
        index  = 8'd0;
        if (cmd.addr < MEM_WORDS) begin
            region = isa_pkg::REG_MEM;
            index  = cmd.addr[7:0];
        end else if (cmd.addr >= isa_pkg::IO_BASE &&
                     cmd.addr < isa_pkg::IO_BASE + isa_pkg::IO_COUNT) begin
            region = isa_pkg::REG_IO;
            index  = io_off[7:0];
        end
    end

    // ########################################
    // Operation flags
    // ########################################

    always_comb begin
        wr_en  = 1'b0;
        rd_ret = 1'b0;
        bad_op = 1'b0;
        case (cmd.op)
            isa_pkg::OP_LOAD: begin
                rd_ret = 1'b1;
            end
            isa_pkg::OP_STORE: begin
                wr_en = 1'b1;
            end
            isa_pkg::OP_SWAP: begin
                wr_en  = 1'b1;
                rd_ret = 1'b1;
            end
            default: begin
                bad_op = 1'b1;
            end
        endcase
    end

    always_ff @(posedge SIM_CLK) begin
        if (cmd_pop) begin
            dec.tag    <= cmd.tag;
            dec.region <= region;
            dec.index  <= index;
            dec.wr_en  <= wr_en & ~bad_op & (region != isa_pkg::REG_BAD);
            dec.rd_ret <= rd_ret;
            dec.bad_op <= bad_op;
            dec.data   <= cmd.data;
        end
    end

    always_ff @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (cmd_pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0; // Taken by execute with nothing behind it.
        end
    end

endmodule

/* hdl/execute_unit.sv */
module execute_unit #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic             SIM_CLK,
    input  logic             arst_n,
    input  logic             dec_valid,
    input  isa_pkg::dec_t    dec,
    output logic             dec_ready,
    output logic             res_valid,
    output link_pkg::result_t res,
    input  logic             res_ready
);

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int IO_AW  = $clog2(isa_pkg::IO_COUNT);

    logic [15:0]       mem [MEM_WORDS];
    logic [15:0]       io_regs [isa_pkg::IO_COUNT];
    logic [MEM_AW-1:0] mem_idx;
    logic [IO_AW-1:0]  io_idx;
    logic              xfer;
    logic [15:0]       old_word;
    link_pkg::status_e status;
    logic [15:0]       ret_data;

    assign dec_ready = ~res_valid | res_ready;
    assign xfer      = dec_valid & dec_ready;
    assign mem_idx   = dec.index[MEM_AW-1:0];
    assign io_idx    = dec.index[IO_AW-1:0];

    // ########################################
    // Read side and result formation
    // ########################################

    always_comb begin
        case (dec.region)
            isa_pkg::REG_MEM: old_word = mem[mem_idx];
            isa_pkg::REG_IO:  old_word = io_regs[io_idx];
            default:          old_word = 16'd0;
        endcase
    end

    always_comb begin
        if (dec.bad_op) begin
            status = link_pkg::ST_BAD_OP; // Wins over a bad address.
        end else if (dec.region == isa_pkg::REG_BAD) begin
            status = link_pkg::ST_BAD_ADDR;
        end else begin
            status = link_pkg::ST_OK;
        end
    end

    always_comb begin
        if (status != link_pkg::ST_OK) begin
            ret_data = 16'd0;
        end else if (dec.rd_ret) begin
            ret_data = old_word;
        end else begin
            ret_data = dec.data;
        end
    end

    // ########################################
    // Write side
    // ########################################

    always_ff @(posedge SIM_CLK) begin
        if (xfer && dec.wr_en && dec.region == isa_pkg::REG_MEM) begin
            mem[mem_idx] <= dec.data;
        end
    end

    always_ff @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < isa_pkg::IO_COUNT; i++) begin
                io_regs[i] <= 16'd0;
            end
        end else if (xfer && dec.wr_en && dec.region == isa_pkg::REG_IO) begin
            io_regs[io_idx] <= dec.data;
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (xfer) begin
            res.tag    <= dec.tag;
            res.status <= status;
            res.data   <= ret_data;
        end
    end

    always_ff @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (xfer) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

endmodule

/* hdl/result_return.sv */
module result_return #(
    parameter int unsigned RES_DEPTH   = 4,
    parameter int unsigned OUT_CREDITS = 4
) (
    input  logic              SIM_CLK,
    input  logic              arst_n,
    input  logic              res_valid,
    input  link_pkg::result_t res,
    output logic              res_ready,
    output logic              out_valid,
    output link_pkg::result_t out_result,
    input  logic              out_credit
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    link_pkg::result_t head;
    logic              buf_not_empty;
    logic              buf_full;
    logic              send;
    logic [CW-1:0]     credits;

    assign res_ready = ~buf_full;
    assign send      = buf_not_empty & (credits != '0);

    credit_fifo #(
        .DEPTH     (RES_DEPTH),
        .payload_t (link_pkg::result_t)
    ) u_res_fifo (
        .SIM_CLK   (SIM_CLK),
        .arst_n    (arst_n),
        .push      (res_valid & res_ready),
        .push_data (res),
        .pop       (send),
        .pop_data  (head),
        .not_empty (buf_not_empty),
        .full      (buf_full),
        .credit    ()
    );

    // ########################################
    // Output credit counter
    // ########################################

    always_ff @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= CW'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits; // Returned and spent in the same cycle.
            endcase
        end
    end

    always_ff @(posedge SIM_CLK) begin
        if (send) begin
            out_result <= head;
        end
    end

endmodule

/* hdl/addr_subsystem_top.sv */
module addr_subsystem_top #(
    parameter int unsigned CMD_DEPTH   = link_pkg::IN_CREDITS,
    parameter int unsigned RES_DEPTH   = link_pkg::OUT_CREDITS,
    parameter int unsigned OUT_CREDITS = link_pkg::OUT_CREDITS,
    parameter int unsigned MEM_WORDS   = 256
) (
    input  logic              SIM_CLK,
    input  logic              arst_n,
    input  logic              in_valid,
    input  isa_pkg::cmd_t     in_cmd,
    output logic              in_credit,
    output logic              out_valid,
    output link_pkg::result_t out_result,
    input  logic              out_credit
);

    isa_pkg::cmd_t     cmd_head;
    logic              cmd_valid;
    logic              cmd_pop;
    logic              cmd_full; // Watched by the checker.
    logic              dec_valid;
    logic              dec_ready;
    isa_pkg::dec_t     dec;
    logic              res_valid;
    logic              res_ready;
    link_pkg::result_t res;

    credit_fifo #(
        .DEPTH     (CMD_DEPTH),
        .payload_t (isa_pkg::cmd_t)
    ) u_cmd_fifo (
        .SIM_CLK   (SIM_CLK),
        .arst_n    (arst_n),
        .push      (in_valid),
        .push_data (in_cmd),
        .pop       (cmd_pop),
        .pop_data  (cmd_head),
        .not_empty (cmd_valid),
        .full      (cmd_full),
        .credit    (in_credit)
    );

    address_decode #(.MEM_WORDS(MEM_WORDS)) u_decode (
        .SIM_CLK   (SIM_CLK),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd_head),
        .cmd_pop   (cmd_pop),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready)
    );

    execute_unit #(.MEM_WORDS(MEM_WORDS)) u_execute (
        .SIM_CLK   (SIM_CLK),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    result_return #(
        .RES_DEPTH   (RES_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_result (
        .SIM_CLK    (SIM_CLK),
        .arst_n     (arst_n),
        .res_valid  (res_valid),
        .res        (res),
        .res_ready  (res_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

endmodule

/* tests/addr_subsystem_chk.sv */
module addr_subsystem_chk #(
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned OUT_CREDITS = link_pkg::OUT_CREDITS
) (
    input logic              SIM_CLK,
    input logic              arst_n,
    input logic              in_valid,
    input isa_pkg::cmd_t     in_cmd,
    input logic              in_credit,
    input logic              cmd_full,
    input logic              out_valid,
    input link_pkg::result_t out_result,
    input logic              out_credit
);

    int                err_count = 0;
    logic [15:0]       shadow_mem [MEM_WORDS]; // Left undefined, like the DUT memory.
    logic [15:0]       shadow_io [8];
    link_pkg::result_t exp_q [64];
    int unsigned       q_wr;
    int unsigned       q_rd;
    int                out_cred;
    int                cmd_owed; // Accepted commands not yet credited back.

    // Result that a command must produce, given the state left by all earlier commands.
    function automatic link_pkg::result_t predict_result(isa_pkg::cmd_t c);
        link_pkg::result_t r;
        logic              is_mem;
        logic              is_io;
        logic [15:0]       old_word;
        is_mem   = (c.addr < MEM_WORDS);
        is_io    = (c.addr >= 9'h1F0) && (c.addr <= 9'h1F7);
        old_word = is_mem ? shadow_mem[c.addr[7:0]] : shadow_io[c.addr[2:0]];
        r.tag    = c.tag;
        r.data   = 16'd0;
        if (c.op > 4'd2) begin
            r.status = link_pkg::ST_BAD_OP;
        end else if (!is_mem && !is_io) begin
            r.status = link_pkg::ST_BAD_ADDR;
        end else begin
            r.status = link_pkg::ST_OK;
            r.data   = (c.op == isa_pkg::OP_STORE) ? c.data : old_word;
        end
        return r;
    endfunction

    // ########################################
    // Reference model
    // ########################################

    always @(posedge SIM_CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                shadow_io[i] <= 16'd0;
            end
            q_wr     <= 0;
            q_rd     <= 0;
            out_cred <= OUT_CREDITS;
            cmd_owed <= 0;
        end else begin
            if (in_valid) begin
                exp_q[q_wr % 64] <= predict_result(in_cmd);
                q_wr <= q_wr + 1;
                if (in_cmd.op == isa_pkg::OP_STORE || in_cmd.op == isa_pkg::OP_SWAP) begin
                    if (in_cmd.addr < MEM_WORDS) begin
                        shadow_mem[in_cmd.addr[7:0]] <= in_cmd.data;
                    end else if (in_cmd.addr >= 9'h1F0 && in_cmd.addr <= 9'h1F7) begin
                        shadow_io[in_cmd.addr[2:0]] <= in_cmd.data;
                    end
                end
            end
            if (out_valid) begin
                q_rd <= q_rd + 1;
            end
            out_cred <= out_cred + int'(out_credit) - int'(out_valid);
            cmd_owed <= cmd_owed + int'(in_valid) - int'(in_credit);
        end
    end

    // ########################################
    // Assertions
    // ########################################

    a_result_order: assert property (@(posedge SIM_CLK) disable iff (!arst_n)
        out_valid |-> (q_rd != q_wr) && (out_result === exp_q[q_rd % 64]))
    else begin
        $error("out_result expected %h actual %h",
               $sampled(exp_q[q_rd % 64]), $sampled(out_result));
        err_count++;
    end

    a_out_credit: assert property (@(posedge SIM_CLK) disable iff (!arst_n)
        out_valid |-> out_cred > 0)
    else begin
        $error("out_valid seen while the DUT held no output credit");
        err_count++;
    end

    a_no_overflow: assert property (@(posedge SIM_CLK) disable iff (!arst_n)
        in_valid |-> !cmd_full)
    else begin
        $error("in_valid seen while the command buffer was full");
        err_count++;
    end

    a_in_credit: assert property (@(posedge SIM_CLK) disable iff (!arst_n)
        in_credit |-> cmd_owed > 0)
    else begin
        $error("in_credit pulse without an accepted command behind it");
        err_count++;
    end

    a_reset_quiet: assert property (@(posedge SIM_CLK)
        (!arst_n || $rose(arst_n)) |-> (!out_valid && !in_credit))
    else begin
        $error("out_valid or in_credit high during or right after reset");
        err_count++;
    end

endmodule

bind addr_subsystem_top addr_subsystem_chk #(
    .MEM_WORDS   (MEM_WORDS),
    .OUT_CREDITS (OUT_CREDITS)
) u_chk (
    .SIM_CLK    (SIM_CLK),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_cmd     (in_cmd),
    .in_credit  (in_credit),
    .cmd_full   (cmd_full),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
);

/* tests/tb_addr_subsystem.sv */
module tb_addr_subsystem;

    localparam int WAIT_LIMIT = 5000; // Cycles any single wait may take.
    localparam int SETTLE     = 12;

    logic              SIM_CLK;
    logic              arst_n;
    logic              in_valid;
    isa_pkg::cmd_t     in_cmd;
    logic              in_credit;
    logic              out_valid;
    link_pkg::result_t out_result;
    logic              out_credit;

    logic [31:0] tx_rng = 32'd94;
    logic [31:0] rx_rng = 32'd94;
    int          sent = 0;
    int          credits_back = 0;
    int          received = 0;
    int          returned = 0;
    int          hold = 0;
    logic        long_holds = 1'b0;
    logic [3:0]  next_tag = 4'd0;
    int          sent_at_start;
    int          recv_at_start;
    int          errs_at_start;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [8:0]  mem_addr [12];
    logic [8:0]  bad_addr [6];

    addr_subsystem_top DUT (
        .SIM_CLK    (SIM_CLK),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_cmd     (in_cmd),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        SIM_CLK = 1'b0;
        forever begin
            #50 SIM_CLK = ~SIM_CLK;
        end
    end

    // ########################################
    // Link monitors and credit return
    // ########################################

    always @(posedge SIM_CLK) begin
        if (in_credit === 1'b1) begin
            credits_back++;
        end
        if (out_valid === 1'b1) begin
            received++;
        end
    end

    initial begin
        out_credit = 1'b0;
        forever begin
            @(negedge SIM_CLK);
            out_credit = 1'b0;
            if (received > returned) begin
                if (hold == 0) begin
                    out_credit = 1'b1;
                    returned++;
                    rx_rng = xorshift(rx_rng);
                    hold   = long_holds ? int'(rx_rng % 48) : int'(rx_rng % 4);
                end else begin
                    hold--;
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Sends one command on a falling edge once the sender holds a credit.
    task automatic send_cmd(input logic [3:0] op, input logic [8:0] addr,
                            input logic [15:0] data);
        int guard;
        guard = 0;
        while (sent - credits_back >= int'(link_pkg::IN_CREDITS)) begin
            @(negedge SIM_CLK);
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_run("Timed out waiting for a command credit from the DUT.");
            end
        end
        in_valid    = 1'b1;
        in_cmd.tag  = next_tag;
        in_cmd.op   = isa_pkg::op_e'(op);
        in_cmd.addr = addr;
        in_cmd.data = data;
        next_tag++;
        sent++;
        @(negedge SIM_CLK);
        in_valid = 1'b0;
    endtask

    task automatic start_test();
        sent_at_start = sent;
        recv_at_start = received;
        errs_at_start = DUT.u_chk.err_count;
    endtask

    task automatic end_test(input string name);
        int guard;
        int exp_n;
        int act_n;
        logic ok;
        guard = 0;
        while (received < sent) begin
            @(negedge SIM_CLK);
            guard++;
            if (guard > WAIT_LIMIT) begin
                abort_run($sformatf("Timed out waiting for the results of test %s.", name));
            end
        end
        repeat (SETTLE) @(negedge SIM_CLK); // Lets any extra result show up.
        exp_n = sent - sent_at_start;
        act_n = received - recv_at_start;
        ok    = (exp_n == act_n) && (DUT.u_chk.err_count == errs_at_start);
        if (exp_n != act_n) begin
            $display("Error: %s result count expected %0d actual %0d", name, exp_n, act_n);
        end
        if (ok) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-16s %s", name, ok ? "passed" : "failed");
    endtask

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_cmd   = '0;
        repeat (10) @(posedge SIM_CLK);
        @(negedge SIM_CLK);
        arst_n = 1'b1;

        start_test();
        repeat (20) @(negedge SIM_CLK);
        for (int i = 0; i < 8; i++) begin
            send_cmd(isa_pkg::OP_LOAD, isa_pkg::IO_BASE + 9'(i), 16'd0);
        end
        end_test("reset_state");

        start_test();
        for (int i = 0; i < 12; i++) begin
            tx_rng      = xorshift(tx_rng);
            mem_addr[i] = {1'b0, tx_rng[7:0]};
            send_cmd(isa_pkg::OP_STORE, mem_addr[i], tx_rng[23:8]);
        end
        for (int i = 0; i < 12; i++) begin
            send_cmd(isa_pkg::OP_LOAD, mem_addr[i], 16'd0);
        end
        end_test("mem_store_load");

        start_test();
        for (int i = 0; i < 8; i++) begin
            tx_rng = xorshift(tx_rng);
            send_cmd(isa_pkg::OP_SWAP, isa_pkg::IO_BASE + 9'(i), tx_rng[15:0]);
            send_cmd(isa_pkg::OP_LOAD, isa_pkg::IO_BASE + 9'(i), 16'd0);
        end
        end_test("io_swap");

        start_test();
        for (int i = 0; i < 6; i++) begin
            tx_rng      = xorshift(tx_rng);
            bad_addr[i] = 9'd256 + 9'(tx_rng % 240);
            send_cmd(isa_pkg::OP_STORE, bad_addr[i], tx_rng[31:16]);
            send_cmd(isa_pkg::OP_SWAP, 9'h1F8 + 9'(tx_rng[2:0]), tx_rng[15:0]);
        end
        for (int op = 3; op < 16; op++) begin
            tx_rng = xorshift(tx_rng);
            send_cmd(4'(op), mem_addr[op % 12], tx_rng[15:0]);
        end
        for (int i = 0; i < 12; i++) begin
            send_cmd(isa_pkg::OP_LOAD, mem_addr[i], 16'd0);
        end
        for (int i = 0; i < 6; i++) begin
            send_cmd(isa_pkg::OP_LOAD, {1'b0, bad_addr[i][7:0]}, 16'd0); // Word a bad store aliases.
        end
        for (int i = 0; i < 8; i++) begin
            send_cmd(isa_pkg::OP_LOAD, isa_pkg::IO_BASE + 9'(i), 16'd0);
        end
        end_test("bad_decode");

        start_test();
        long_holds = 1'b1; // Receiver sits on its credits for long stretches.
        for (int i = 0; i < 40; i++) begin
            tx_rng = xorshift(tx_rng);
            send_cmd(4'(tx_rng % 3),
                     tx_rng[8] ? isa_pkg::IO_BASE + 9'(tx_rng[11:9]) : mem_addr[tx_rng[15:12] % 12],
                     tx_rng[31:16]);
        end
        end_test("backpressure");
        long_holds = 1'b0;

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && DUT.u_chk.err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/isa_pkg.sv
hdl/link_pkg.sv
hdl/credit_fifo.sv
hdl/address_decode.sv
hdl/execute_unit.sv
hdl/result_return.sv
hdl/addr_subsystem_top.sv
tests/addr_subsystem_chk.sv
tests/tb_addr_subsystem.sv

/* Bender.yml */
package:
  name: addr_subsystem

sources:
  # Packages first, then the blocks, then the top level.
  - hdl/isa_pkg.sv
  - hdl/link_pkg.sv
  - hdl/credit_fifo.sv
  - hdl/address_decode.sv
  - hdl/execute_unit.sv
  - hdl/result_return.sv
  - hdl/addr_subsystem_top.sv

  - target: test
    files:
      - tests/addr_subsystem_chk.sv
      - tests/tb_addr_subsystem.sv
